// ==== hdl/apb_regs.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "uart_params.svh"

module apb_regs
    import uart_bus_pkg::*, uart_line_pkg::*;
(
    input  logic        ck,
    input  logic        rst,
    input  apb_req_t    req,
    output apb_rsp_t    rsp,
    output logic        tx_push,
    output tx_byte_t    tx_data,
    input  logic        tx_full,
    input  logic        tx_empty,
    output logic        rx_pop,
    input  rx_entry_t   rx_head,
    input  logic        rx_empty,
    input  logic        tx_busy,
    output logic [15:0] divisor
);

    logic         access;
    logic         sel_data;
    logic         sel_status;
    logic         sel_div;
    logic [15:0]  div_q;
    uart_status_t status;

    assign access     = req.psel && req.penable;
    assign sel_data   = req.paddr == `UART_ADDR_DATA;
    assign sel_status = req.paddr == `UART_ADDR_STATUS;
    assign sel_div    = req.paddr == `UART_ADDR_DIV;

    // full fifo drops the byte, empty fifo is never popped
    assign tx_push      = access && req.pwrite && sel_data && !tx_full;
    assign tx_data.data = req.pwdata[7:0];
    assign rx_pop       = access && !req.pwrite && sel_data && !rx_empty;

    assign status.tx_full      = tx_full;
    assign status.tx_empty     = tx_empty;
    assign status.rx_valid     = !rx_empty;
    assign status.rx_frame_err = !rx_empty && rx_head.frame_err;
    assign status.tx_busy      = tx_busy;

    always_comb begin
        rsp        = '0;
        rsp.pready = 1'b1;
        if (access) begin
            if (sel_data) begin
                if (req.pwrite) begin
                    rsp.pslverr = tx_full;
                end else if (rx_empty) begin
                    rsp.pslverr = 1'b1;
                end else begin
                    rsp.prdata = 32'(rx_head);
                end
            end else if (sel_status && !req.pwrite) begin
                rsp.prdata = 32'(status);
            end else if (sel_div && !req.pwrite) begin
                rsp.prdata = {16'h0000, div_q};
            end
        end
    end

    always_ff @(posedge ck) begin
        if (rst) begin
            div_q <= `UART_DIV_RESET;
        end else if (access && req.pwrite && sel_div) begin
            div_q <= req.pwdata[15:0];
        end
    end

    assign divisor = div_q;

    // a setup cycle is always followed by its access cycle
    assert property (@(posedge ck) disable iff (rst)
        req.psel && !req.penable |=> req.psel && req.penable)
        else $error("apb setup phase not followed by access phase");

endmodule

`default_nettype wire

// ==== hdl/baud_gen.sv ====
`default_nettype none
`timescale 1ns/10ps

module baud_gen (
    input  logic        ck,
    input  logic        rst,
    input  logic [15:0] divisor,
    output logic        tick
);

    logic [15:0] count;

    // counts down from divisor, so one tick per divisor+1 clocks
    always_ff @(posedge ck) begin
        if (rst) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (count == '0) begin
            count <= divisor;
            tick  <= 1'b1;
        end else begin
            count <= count - 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "uart_params.svh"

module sync_fifo #(
    parameter type item_t = logic [7:0]
) (
    input  logic  ck,
    input  logic  rst,
    input  logic  push,
    input  item_t din,
    input  logic  pop,
    output item_t dout,
    output logic  full,
    output logic  empty
);

    localparam int DEPTH = `UART_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

    item_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;

    always_ff @(posedge ck) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge ck) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // head entry is visible without a pop
    assign dout  = mem[rd_ptr];
    assign full  = count == FULL_COUNT;
    assign empty = count == '0;

    assert property (@(posedge ck) disable iff (rst) !(push && full))
        else $error("push into full fifo");
    assert property (@(posedge ck) disable iff (rst) !(pop && empty))
        else $error("pop from empty fifo");

endmodule

`default_nettype wire

// ==== hdl/uart_apb.sv ====
`default_nettype none
`timescale 1ns/10ps

module uart_apb
    import uart_bus_pkg::*, uart_line_pkg::*;
(
    input  logic     ck,
    input  logic     rst,
    input  apb_req_t req,
    output apb_rsp_t rsp,
    input  logic     rxd,
    output logic     txd
);

    logic        tx_push, tx_pop, tx_full, tx_empty, tx_busy;
    tx_byte_t    tx_data, tx_head;
    logic        rx_push, rx_push_ok, rx_pop, rx_full, rx_empty;
    rx_entry_t   rx_entry, rx_head;
    logic [15:0] divisor;
    logic        tick;

    // an entry arriving at a full receive fifo is lost
    assign rx_push_ok = rx_push && !rx_full;

    apb_regs regs (
        .ck(ck), .rst(rst), .req(req), .rsp(rsp),
        .tx_push(tx_push), .tx_data(tx_data), .tx_full(tx_full), .tx_empty(tx_empty),
        .rx_pop(rx_pop), .rx_head(rx_head), .rx_empty(rx_empty),
        .tx_busy(tx_busy), .divisor(divisor)
    );

    sync_fifo #(.item_t(tx_byte_t)) tx_fifo (
        .ck(ck), .rst(rst), .push(tx_push), .din(tx_data), .pop(tx_pop),
        .dout(tx_head), .full(tx_full), .empty(tx_empty)
    );

    sync_fifo #(.item_t(rx_entry_t)) rx_fifo (
        .ck(ck), .rst(rst), .push(rx_push_ok), .din(rx_entry), .pop(rx_pop),
        .dout(rx_head), .full(rx_full), .empty(rx_empty)
    );

    baud_gen baud (.ck(ck), .rst(rst), .divisor(divisor), .tick(tick));

    uart_tx tx (
        .ck(ck), .rst(rst), .tick(tick), .fifo_empty(tx_empty), .fifo_data(tx_head),
        .fifo_pop(tx_pop), .busy(tx_busy), .txd(txd)
    );

    uart_rx rx (.ck(ck), .rst(rst), .tick(tick), .rxd(rxd), .push(rx_push), .entry(rx_entry));

endmodule

`default_nettype wire

// ==== hdl/uart_bus_pkg.sv ====
`default_nettype none

package uart_bus_pkg;

    typedef struct packed {
        logic [7:0]  paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // first member is the msb, so tx_full lands in bit 0
    typedef struct packed {
        logic tx_busy;
        logic rx_frame_err;
        logic rx_valid;
        logic tx_empty;
        logic tx_full;
    } uart_status_t;

endpackage

`default_nettype wire

// ==== hdl/uart_line_pkg.sv ====
`default_nettype none

package uart_line_pkg;

    // one byte waiting for the transmitter
    typedef struct packed {
        logic [7:0] data;
    } tx_byte_t;

    // received byte with frame_err above the data in bit 8
    typedef struct packed {
        logic       frame_err;
        logic [7:0] data;
    } rx_entry_t;

    // start + 8 data + stop
    localparam int FRAME_BITS = 10;

endpackage

`default_nettype wire

// ==== hdl/uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// fifo and line timing
`define UART_FIFO_DEPTH  8
`define UART_OVERSAMPLE  16
`define UART_DIV_RESET   16'd3

// register offsets on the apb side
`define UART_ADDR_DATA   8'h00
`define UART_ADDR_STATUS 8'h04
`define UART_ADDR_DIV    8'h08

`endif

// ==== hdl/uart_rx.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "uart_params.svh"

module uart_rx
    import uart_line_pkg::*;
(
    input  logic      ck,
    input  logic      rst,
    input  logic      tick,
    input  logic      rxd,
    output logic      push,
    output rx_entry_t entry
);

    localparam logic [3:0] TICK_MID  = 4'(`UART_OVERSAMPLE / 2 - 1);
    localparam logic [3:0] TICK_LAST = 4'(`UART_OVERSAMPLE - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t  state;
    logic       rxd_meta;
    logic       rxd_sync;
    logic       rxd_prev;
    logic [3:0] tick_cnt;
    logic [2:0] bit_cnt;
    logic [7:0] data_sr;

    always_ff @(posedge ck) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame fsm sampling each bit at its midpoint
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge ck) begin
        if (rst) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            push     <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (rxd_prev && !rxd_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: if (tick) begin
                    if (tick_cnt == TICK_MID) begin
                        // a start bit that went high again was a glitch
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rxd_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_DATA: if (tick) begin
                    if (tick_cnt == TICK_LAST) begin
                        tick_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_STOP: if (tick) begin
                    if (tick_cnt == TICK_LAST) begin
                        push  <= 1'b1;
                        state <= RX_IDLE;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge ck) begin
        if (state == RX_DATA && tick && tick_cnt == TICK_LAST) begin
            data_sr <= {rxd_sync, data_sr[7:1]};
        end
        if (state == RX_STOP && tick && tick_cnt == TICK_LAST) begin
            entry.data      <= data_sr;
            entry.frame_err <= !rxd_sync;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "uart_params.svh"

module uart_tx
    import uart_line_pkg::*;
(
    input  logic     ck,
    input  logic     rst,
    input  logic     tick,
    input  logic     fifo_empty,
    input  tx_byte_t fifo_data,
    output logic     fifo_pop,
    output logic     busy,
    output logic     txd
);

    localparam logic [3:0] TICK_LAST = 4'(`UART_OVERSAMPLE - 1);
    localparam logic [3:0] BIT_LAST  = 4'(FRAME_BITS - 1);

    logic [9:0] shift;
    logic [3:0] bit_cnt;
    logic [3:0] tick_cnt;

    assign fifo_pop = !busy && !fifo_empty;

    always_ff @(posedge ck) begin
        if (rst) begin
            busy     <= 1'b0;
            shift    <= '1;
            bit_cnt  <= '0;
            tick_cnt <= '0;
        end else if (fifo_pop) begin
            // stop, data lsb first, start
            busy     <= 1'b1;
            shift    <= {1'b1, fifo_data.data, 1'b0};
            bit_cnt  <= '0;
            tick_cnt <= '0;
        end else if (busy && tick) begin
            if (tick_cnt == TICK_LAST) begin
                tick_cnt <= '0;
                shift    <= {1'b1, shift[9:1]};
                if (bit_cnt == BIT_LAST) begin
                    busy <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    assign txd = shift[0];

    // line idles at mark between frames
    assert property (@(posedge ck) disable iff (rst) !busy |-> txd)
        else $error("txd low while transmitter idle");

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the uart testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module uart_apb_tb \
    -f src.f -o uart_apb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/uart_apb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -q "Test completed successfully" "$LOG" || exit 1
exit 0

// ==== src.f ====
+incdir+hdl
hdl/uart_bus_pkg.sv
hdl/uart_line_pkg.sv
hdl/sync_fifo.sv
hdl/baud_gen.sv
hdl/apb_regs.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_apb.sv
tb/uart_apb_tb.sv

// ==== tb/uart_apb_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "uart_params.svh"

module uart_apb_tb
    import uart_bus_pkg::*, uart_line_pkg::*;
();

    localparam int          CLK_NS          = 10;
    localparam logic [15:0] DIV_SLOW        = 16'd63;
    localparam int          FRAME_TICKS     = `UART_OVERSAMPLE * 10;
    localparam int          SLOW_FRAME_CLKS = FRAME_TICKS * (int'(DIV_SLOW) + 1);
    localparam int          FAST_BIT_CLKS   = `UART_OVERSAMPLE * (int'(`UART_DIV_RESET) + 1);
    // one bus transfer takes three clocks
    localparam int          POLL_LIMIT      = SLOW_FRAME_CLKS / 3;
    localparam int          WATCHDOG_NS     = 20 * SLOW_FRAME_CLKS * CLK_NS + 50000;

    logic     ck;
    logic     rst;
    apb_req_t req;
    apb_rsp_t rsp;
    logic     rxd;
    logic     txd;
    logic     rxd_drive;
    logic     loopback;
    integer   seed;
    int       err_count;
    int       tests_run;
    int       tests_failed;

    assign rxd = loopback ? txd : rxd_drive;

    uart_apb UUT (.ck(ck), .rst(rst), .req(req), .rsp(rsp), .rxd(rxd), .txd(txd));

    always #5 ck = ~ck;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus and line drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic apb_transfer(input logic [7:0] addr, input logic write,
                                input logic [31:0] wdata, output apb_rsp_t rsp_out);
        @(posedge ck);
        req.paddr   <= addr;
        req.pwrite  <= write;
        req.pwdata  <= wdata;
        req.psel    <= 1'b1;
        req.penable <= 1'b0;
        @(posedge ck);
        req.penable <= 1'b1;
        // response settles inside the access cycle
        @(negedge ck);
        rsp_out = rsp;
        @(posedge ck);
        req.psel    <= 1'b0;
        req.penable <= 1'b0;
    endtask

    // start, data lsb first, then the given stop level
    task automatic drive_frame(input logic [7:0] data, input logic stop);
        logic [9:0] bits;
        bits = {stop, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge ck);
            rxd_drive <= bits[i];
            repeat (FAST_BIT_CLKS - 1) @(posedge ck);
        end
        @(posedge ck);
        rxd_drive <= 1'b1;
    endtask

    // polls status for rx_valid, or for an empty and idle transmitter
    task automatic wait_status(input string name, input bit want_tx_idle, output bit seen);
        apb_rsp_t     r;
        uart_status_t s;
        int           polls;
        seen  = 1'b0;
        polls = 0;
        while (!seen && polls < POLL_LIMIT) begin
            apb_transfer(`UART_ADDR_STATUS, 1'b0, 32'h0, r);
            s     = uart_status_t'(r.prdata[4:0]);
            seen  = want_tx_idle ? (s.tx_empty && !s.tx_busy) : s.rx_valid;
            polls = polls + 1;
        end
        if (!seen) begin
            $display("%s: status never reached the awaited state before the poll limit", name);
            err_count++;
        end
    endtask

    function automatic apb_rsp_t make_rsp(input logic [31:0] prdata, input logic pslverr);
        apb_rsp_t r;
        r.prdata  = prdata;
        r.pready  = 1'b1;
        r.pslverr = pslverr;
        return r;
    endfunction

    function automatic uart_status_t make_status(input logic full, input logic empty,
                                                 input logic valid, input logic ferr,
                                                 input logic busy);
        uart_status_t s;
        s.tx_full      = full;
        s.tx_empty     = empty;
        s.rx_valid     = valid;
        s.rx_frame_err = ferr;
        s.tx_busy      = busy;
        return s;
    endfunction

    function automatic rx_entry_t make_entry(input logic ferr, input logic [7:0] data);
        rx_entry_t e;
        e.frame_err = ferr;
        e.data      = data;
        return e;
    endfunction

    task automatic check_rsp(input string name, input apb_rsp_t exp, input apb_rsp_t act);
        if (act !== exp) begin
            $write("[FAIL] %s: expected prdata=%h pready=%b pslverr=%b",
                   name, exp.prdata, exp.pready, exp.pslverr);
            $display(", actual prdata=%h pready=%b pslverr=%b",
                     act.prdata, act.pready, act.pslverr);
            err_count++;
        end
    endtask

    task automatic check_status(input string name, input uart_status_t exp,
                                input uart_status_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected status=%b, actual status=%b", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_entry(input string name, input rx_entry_t exp, input rx_entry_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected frame_err=%b data=%h, actual frame_err=%b data=%h",
                     name, exp.frame_err, exp.data, act.frame_err, act.data);
            err_count++;
        end
    endtask

    task automatic end_test(input string name, input int start);
        tests_run++;
        if (err_count == start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - start);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic reset_state();
        int       start;
        apb_rsp_t r;
        start = err_count;
        apb_transfer(`UART_ADDR_STATUS, 1'b0, 32'h0, r);
        check_status("reset status", make_status(0, 1, 0, 0, 0), uart_status_t'(r.prdata[4:0]));
        apb_transfer(`UART_ADDR_DIV, 1'b0, 32'h0, r);
        check_rsp("reset div", make_rsp({16'h0000, `UART_DIV_RESET}, 1'b0), r);
        if (txd !== 1'b1) begin
            $display("[FAIL] reset txd: expected txd=1, actual txd=%b", txd);
            err_count++;
        end
        end_test("reset_state", start);
    endtask

    task automatic div_access();
        int       start;
        apb_rsp_t r;
        start = err_count;
        apb_transfer(`UART_ADDR_DIV, 1'b1, 32'hABCD_0005, r);
        check_rsp("div write", make_rsp(32'h0, 1'b0), r);
        apb_transfer(`UART_ADDR_DIV, 1'b0, 32'h0, r);
        check_rsp("div readback", make_rsp(32'h0000_0005, 1'b0), r);
        // unmapped offset
        apb_transfer(8'h0C, 1'b1, 32'hFFFF_FFFF, r);
        check_rsp("unmapped write", make_rsp(32'h0, 1'b0), r);
        apb_transfer(8'h0C, 1'b0, 32'h0, r);
        check_rsp("unmapped read", make_rsp(32'h0, 1'b0), r);
        apb_transfer(`UART_ADDR_DIV, 1'b0, 32'h0, r);
        check_rsp("div after unmapped", make_rsp(32'h0000_0005, 1'b0), r);
        apb_transfer(`UART_ADDR_STATUS, 1'b0, 32'h0, r);
        check_status("status after unmapped", make_status(0, 1, 0, 0, 0),
                     uart_status_t'(r.prdata[4:0]));
        apb_transfer(`UART_ADDR_DIV, 1'b1, {16'h0000, `UART_DIV_RESET}, r);
        end_test("div_access", start);
    endtask

    task automatic loopback_bytes();
        int          start;
        logic [31:0] rnd;
        logic [7:0]  sent [6];
        apb_rsp_t    r;
        bit          seen;
        start    = err_count;
        loopback <= 1'b1;
        for (int i = 0; i < 6; i++) begin
            rnd     = $random(seed);
            sent[i] = rnd[7:0];
            apb_transfer(`UART_ADDR_DATA, 1'b1, rnd, r);
            check_rsp("loopback write", make_rsp(32'h0, 1'b0), r);
        end
        for (int i = 0; i < 6; i++) begin
            wait_status("loopback_bytes", 1'b0, seen);
            if (!seen) begin
                break;
            end
            apb_transfer(`UART_ADDR_DATA, 1'b0, 32'h0, r);
            check_entry("loopback read", make_entry(1'b0, sent[i]), rx_entry_t'(r.prdata[8:0]));
        end
        wait_status("loopback_bytes", 1'b1, seen);
        loopback <= 1'b0;
        end_test("loopback_bytes", start);
    endtask

    task automatic tx_overflow();
        int          start;
        logic [31:0] rnd;
        apb_rsp_t    r;
        bit          seen;
        start = err_count;
        apb_transfer(`UART_ADDR_DIV, 1'b1, {16'h0000, DIV_SLOW}, r);
        // one byte goes to the shifter, eight fill the fifo
        for (int i = 0; i < 10; i++) begin
            rnd = $random(seed);
            apb_transfer(`UART_ADDR_DATA, 1'b1, rnd, r);
            check_rsp("overflow write", make_rsp(32'h0, i == 9), r);
        end
        apb_transfer(`UART_ADDR_STATUS, 1'b0, 32'h0, r);
        check_status("overflow status", make_status(1, 0, 0, 0, 1),
                     uart_status_t'(r.prdata[4:0]));
        apb_transfer(`UART_ADDR_DIV, 1'b1, {16'h0000, `UART_DIV_RESET}, r);
        wait_status("tx_overflow", 1'b1, seen);
        end_test("tx_overflow", start);
    endtask

    task automatic empty_read();
        int       start;
        apb_rsp_t r;
        start = err_count;
        apb_transfer(`UART_ADDR_DATA, 1'b0, 32'h0, r);
        check_rsp("empty data read", make_rsp(32'h0, 1'b1), r);
        end_test("empty_read", start);
    endtask

    task automatic framing_error();
        int          start;
        logic [31:0] rnd;
        apb_rsp_t    r;
        bit          seen;
        start = err_count;
        rnd   = $random(seed);
        drive_frame(rnd[7:0], 1'b0);
        wait_status("framing_error", 1'b0, seen);
        apb_transfer(`UART_ADDR_STATUS, 1'b0, 32'h0, r);
        check_status("frame error status", make_status(0, 1, 1, 1, 0),
                     uart_status_t'(r.prdata[4:0]));
        apb_transfer(`UART_ADDR_DATA, 1'b0, 32'h0, r);
        check_entry("frame error read", make_entry(1'b1, rnd[7:0]), rx_entry_t'(r.prdata[8:0]));
        end_test("framing_error", start);
    endtask

    initial begin
        ck           = 1'b0;
        rst          = 1'b1;
        req          = '0;
        rxd_drive    = 1'b1;
        loopback     = 1'b0;
        seed         = 17;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(posedge ck);
        rst <= 1'b0;

        reset_state();
        div_access();
        loopback_bytes();
        tx_overflow();
        empty_read();
        framing_error();

        $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // sized for twenty frames at the slow divisor
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
